// File: xc_pkg.sv
package xc_pkg;

	// sizes of the correlator array.
	localparam int num_lines = 8; // number of digital input lines.
	localparam int num_pairs = num_lines * (num_lines - 1) / 2; // unordered pairs at lag zero.
	localparam int num_counts = num_lines + num_pairs; // auto counts first, then cross counts.

	localparam int count_width = 16; // every counter wraps at this width.
	localparam int count_bytes = count_width / 8; // bytes per count on the serial link.

	// a readout frame is one header byte followed by every count, low byte first.
	localparam logic [7:0] frame_header = 8'hA5; // marks the start of each frame.
	localparam int frame_bytes = 1 + num_counts * count_bytes; // header plus payload bytes.
	localparam int frame_index_width = $clog2(frame_bytes + 1); // also holds the end index.

endpackage

// File: xc_uart_pkg.sv
package xc_uart_pkg;

	localparam int clk_frequency = 10000000; // the sysclk rate in hertz.
	localparam int baud_rate = 625000; // serial link speed in bits per second.
	localparam int clks_per_bit = clk_frequency / baud_rate; // sysclk cycles in one bit time.
	localparam int bit_timer_width = $clog2(clks_per_bit); // counts one bit time.
	localparam int frame_bits = 10; // start bit, eight data bits and one stop bit.

	// single byte commands from the host.
	localparam logic [7:0] cmd_start = 8'h73; // ascii s clears the counts and starts.
	localparam logic [7:0] cmd_stop = 8'h74; // ascii t stops the integration.
	localparam logic [7:0] cmd_read = 8'h72; // ascii r reads out the counts.

endpackage

// File: xc_line_sampler.sv
`timescale 1ns/1ps

module xc_line_sampler (
	input logic sysclk,
	input logic reset,
	input logic [xc_pkg::num_lines-1:0] line_in,
	input logic strobe,
	output logic sample_valid,
	output logic [xc_pkg::num_lines-1:0] sample_lines,
	output logic smpclk
);
	import xc_pkg::*;

	logic strobe_meta; // first synchronizer stage of the strobe.
	logic strobe_sync; // second synchronizer stage of the strobe.
	logic strobe_last; // previous synchronized strobe level for the edge detect.
	logic strobe_rise; // the synchronized strobe has just gone high.
	logic [num_lines-1:0] lines_meta; // lines take the same two stages as the strobe.
	logic [num_lines-1:0] lines_sync;

	assign strobe_rise = strobe_sync && !strobe_last; // one cycle per rising edge.

	always_ff @(posedge sysclk) begin
		if (reset) begin
			strobe_meta <= 1'b0;
			strobe_sync <= 1'b0;
			strobe_last <= 1'b0;
			sample_valid <= 1'b0;
			smpclk <= 1'b0; // the monitor pin starts low.
		end else begin
			strobe_meta <= strobe;
			strobe_sync <= strobe_meta;
			strobe_last <= strobe_sync;
			sample_valid <= strobe_rise; // the pulse leaves on the third stage.
			if (strobe_rise)
				smpclk <= ~smpclk; // one level change per sample shows the rate.
		end
	end

	always_ff @(posedge sysclk) begin
		lines_meta <= line_in;
		lines_sync <= lines_meta;
		if (strobe_rise)
			sample_lines <= lines_sync; // held until the next sample.
	end

	// strobe phases of at least three cycles keep the pulses six cycles apart.
	assert property (@(posedge sysclk) disable iff (reset) sample_valid |=> !sample_valid [*5]);

endmodule

// File: xc_correlator.sv
`timescale 1ns/1ps

module xc_correlator (
	input logic sysclk,
	input logic reset,
	input logic sample_valid,
	input logic [xc_pkg::num_lines-1:0] sample_lines,
	input logic clear,
	input logic run,
	input logic snapshot,
	output logic [xc_pkg::num_counts*xc_pkg::count_width-1:0] snap_counts
);
	import xc_pkg::*;

	// returns the lower or the higher line of a pair, pairs ordered (0,1), (0,2) ... (6,7).
	function automatic int pair_line(input int pair, input bit second);
		int k;
		int sel;
		k = 0;
		sel = 0;
		for (int i = 0; i < num_lines; i++) begin
			for (int j = i + 1; j < num_lines; j++) begin
				if (k == pair)
					sel = second ? j : i;
				k++;
			end
		end
		return sel;
	endfunction

	logic count_enable; // a sample arrives while integration runs.
	logic [num_counts*count_width-1:0] live_counts; // all counters, count 0 in the low bits.

	assign count_enable = run && sample_valid;

	for (genvar a = 0; a < num_lines; a++) begin : g_auto
		logic [count_width-1:0] count; // high samples seen on this line.
		always_ff @(posedge sysclk) begin
			if (reset || clear)
				count <= '0; // clear wins over a sample in the same cycle.
			else if (count_enable && sample_lines[a])
				count <= count + 1'b1; // wraps modulo the counter width.
		end
		assign live_counts[a*count_width +: count_width] = count;
	end

	for (genvar p = 0; p < num_pairs; p++) begin : g_cross
		localparam int low = pair_line(p, 1'b0); // first line of this pair.
		localparam int high = pair_line(p, 1'b1); // second line of this pair.
		logic [count_width-1:0] count; // samples with both lines high.
		always_ff @(posedge sysclk) begin
			if (reset || clear)
				count <= '0;
			else if (count_enable && sample_lines[low] && sample_lines[high])
				count <= count + 1'b1;
		end
		assign live_counts[(num_lines+p)*count_width +: count_width] = count;
	end

	always_ff @(posedge sysclk) begin
		if (snapshot)
			snap_counts <= live_counts; // frozen while the frame goes out.
	end

	// the sender never issues both in one cycle, so a snapshot never sees half cleared counts.
	assert property (@(posedge sysclk) disable iff (reset) !(clear && snapshot));

endmodule

// File: xc_uart_rx.sv
`timescale 1ns/1ps

module xc_uart_rx (
	input logic sysclk,
	input logic reset,
	input logic rx,
	output logic rx_valid,
	output logic [7:0] rx_data
);
	import xc_uart_pkg::*;

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

	rx_state_t state; // position within the serial frame.
	logic rx_meta; // first synchronizer stage of the line.
	logic rx_sync; // second synchronizer stage of the line.
	logic [bit_timer_width-1:0] timer; // cycles since the last sampling point.
	logic [2:0] bit_index; // data bit being received.
	logic [7:0] shift; // data bits arrive lsb first.
	logic bit_end; // one bit time has passed.
	logic start_mid; // middle of the start bit.
	logic sample_bit; // take a data bit in the middle of its bit time.
	logic byte_done; // the stop bit is good and the byte is complete.

	assign bit_end = timer == bit_timer_width'(clks_per_bit - 1);
	assign start_mid = timer == bit_timer_width'(clks_per_bit / 2 - 1);
	assign sample_bit = (state == st_data) && bit_end;
	assign byte_done = (state == st_stop) && bit_end && rx_sync; // bad stop bits drop the byte.

	always_ff @(posedge sysclk) begin
		if (reset) begin
			rx_meta <= 1'b1; // the line idles high.
			rx_sync <= 1'b1;
			state <= st_idle;
			timer <= '0;
			bit_index <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_valid <= byte_done;
			timer <= timer + 1'b1;
			case (state)
				st_idle: begin
					timer <= '0;
					if (!rx_sync)
						state <= st_start; // falling edge may be a start bit.
				end
				st_start: if (start_mid) begin
					timer <= '0; // later sampling points fall mid bit.
					bit_index <= '0;
					state <= rx_sync ? st_idle : st_data; // a short glitch is no start bit.
				end
				st_data: if (bit_end) begin
					timer <= '0;
					bit_index <= bit_index + 1'b1;
					if (bit_index == 3'd7)
						state <= st_stop;
				end
				default: if (bit_end)
					state <= st_idle; // the next falling edge can follow at once.
			endcase
		end
	end

	always_ff @(posedge sysclk) begin
		if (sample_bit)
			shift <= {rx_sync, shift[7:1]};
		if (byte_done)
			rx_data <= shift;
	end

endmodule

// File: xc_uart_tx.sv
`timescale 1ns/1ps

module xc_uart_tx (
	input logic sysclk,
	input logic reset,
	input logic tx_start,
	input logic [7:0] tx_data,
	output logic tx,
	output logic tx_busy
);
	import xc_uart_pkg::*;

	logic [frame_bits-1:0] frame; // bit 0 is the level on the line.
	logic [bit_timer_width-1:0] timer; // cycles into the current bit.
	logic [3:0] bit_index; // bit of the frame being sent.
	logic bit_end; // last cycle of the current bit.

	assign bit_end = timer == bit_timer_width'(clks_per_bit - 1);
	assign tx = frame[0];

	always_ff @(posedge sysclk) begin
		if (reset) begin
			frame <= '1; // the line idles high.
			tx_busy <= 1'b0;
			timer <= '0;
			bit_index <= '0;
		end else if (tx_start && !tx_busy) begin
			frame <= {1'b1, tx_data, 1'b0}; // stop bit, data lsb first, start bit.
			tx_busy <= 1'b1; // rises one cycle after the start pulse.
			timer <= '0;
			bit_index <= '0;
		end else if (tx_busy) begin
			if (bit_end) begin
				timer <= '0;
				frame <= {1'b1, frame[frame_bits-1:1]}; // ones fill in behind the stop bit.
				bit_index <= bit_index + 1'b1;
				if (bit_index == 4'(frame_bits - 1))
					tx_busy <= 1'b0; // falls once the stop bit has been sent.
			end else begin
				timer <= timer + 1'b1;
			end
		end
	end

	// the frame sender only starts a byte once the previous one has gone out.
	assert property (@(posedge sysclk) disable iff (reset) tx_start |-> !tx_busy);

endmodule

// File: xc_frame_sender.sv
`timescale 1ns/1ps

module xc_frame_sender (
	input logic sysclk,
	input logic reset,
	input logic rx_valid,
	input logic [7:0] rx_data,
	input logic [xc_pkg::num_counts*xc_pkg::count_width-1:0] snap_counts,
	input logic tx_busy,
	output logic clear,
	output logic run,
	output logic snapshot,
	output logic tx_start,
	output logic [7:0] tx_data
);
	import xc_pkg::*;
	import xc_uart_pkg::*;

	logic active; // a frame is being sent.
	logic [frame_index_width-1:0] byte_index; // bytes of the frame handed to the transmitter.
	logic send_slot; // the transmitter is free and no start is in flight.
	logic [7:0] next_byte; // header first, then the snapshot bytes in order.

	assign send_slot = active && !tx_busy && !tx_start;
	assign next_byte = (byte_index == '0) ? frame_header
		: snap_counts[(byte_index - 1'b1) * 8 +: 8];

	always_ff @(posedge sysclk) begin
		if (reset) begin
			clear <= 1'b0;
			run <= 1'b0;
			snapshot <= 1'b0;
			tx_start <= 1'b0;
			active <= 1'b0;
			byte_index <= '0;
		end else begin
			clear <= 1'b0; // pulses last one cycle.
			snapshot <= 1'b0;
			tx_start <= 1'b0;
			if (rx_valid) begin
				case (rx_data)
					cmd_start: begin
						clear <= 1'b1;
						run <= 1'b1;
					end
					cmd_stop: run <= 1'b0;
					cmd_read: if (!active) begin
						snapshot <= 1'b1; // a read during a frame is ignored.
						active <= 1'b1;
						byte_index <= '0;
					end
					default: ; // unknown bytes change nothing.
				endcase
			end
			if (send_slot) begin
				if (byte_index == frame_index_width'(frame_bytes)) begin
					active <= 1'b0; // the last stop bit has gone out.
				end else begin
					tx_start <= 1'b1;
					byte_index <= byte_index + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sysclk) begin
		if (send_slot)
			tx_data <= next_byte;
	end

endmodule

// File: main.sv
`timescale 1ns/1ps

module main (
	input logic sysclk,
	input logic reset,
	input logic rx,
	output logic tx,
	input logic [xc_pkg::num_lines-1:0] line_in,
	input logic strobe,
	output logic smpclk
);
	import xc_pkg::*;

	logic sample_valid; // one pulse per strobe rising edge.
	logic [num_lines-1:0] sample_lines; // line word captured with that pulse.
	logic rx_valid; // a command byte has arrived.
	logic [7:0] rx_data;
	logic clear; // zeroes every counter.
	logic run; // integration is running.
	logic snapshot; // freezes the counts for a readout.
	logic [num_counts*count_width-1:0] snap_counts;
	logic tx_start; // hands one byte to the transmitter.
	logic [7:0] tx_data;
	logic tx_busy;

	xc_line_sampler sampler_i (
		.sysclk(sysclk),
		.reset(reset),
		.line_in(line_in),
		.strobe(strobe),
		.sample_valid(sample_valid),
		.sample_lines(sample_lines),
		.smpclk(smpclk)
	);

	xc_correlator correlator_i (
		.sysclk(sysclk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_lines(sample_lines),
		.clear(clear),
		.run(run),
		.snapshot(snapshot),
		.snap_counts(snap_counts)
	);

	xc_uart_rx uart_rx_i (
		.sysclk(sysclk),
		.reset(reset),
		.rx(rx),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	xc_frame_sender frame_sender_i (
		.sysclk(sysclk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.snap_counts(snap_counts),
		.tx_busy(tx_busy),
		.clear(clear),
		.run(run),
		.snapshot(snapshot),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	xc_uart_tx uart_tx_i (
		.sysclk(sysclk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(tx),
		.tx_busy(tx_busy)
	);

endmodule

// File: xc_firmware.sv
`timescale 1ns/1ps

module xc_firmware (
	input wire sysclk,
	input wire reset,
	inout wire [19:0] jp1,
	inout wire [19:0] jp2
);
	import xc_pkg::*;

	wire tx; // serial data to the host.
	wire rx; // serial commands from the host.
	wire strobe; // external sample strobe.
	wire smpclk; // sample clock monitor.
	wire [num_lines-1:0] line_in;

	assign line_in[0] = jp1[15]; // lines 0 to 3 sit on the first header.
	assign line_in[1] = jp1[13];
	assign line_in[2] = jp1[11];
	assign line_in[3] = jp1[9];
	assign line_in[4] = jp2[15]; // lines 4 to 7 sit on the second header.
	assign line_in[5] = jp2[13];
	assign line_in[6] = jp2[11];
	assign line_in[7] = jp2[9];

	assign strobe = jp2[16];
	assign rx = jp2[19];
	assign jp2[18] = tx;
	assign jp1[19] = smpclk;

	// clock outputs and led or dac pins without a function here are held low.
	assign jp1[18] = 1'b0; // internal clock output.
	assign jp1[17] = 1'b0; // reference clock output.
	assign jp1[14] = 1'b0;
	assign jp1[12] = 1'b0;
	assign jp1[10] = 1'b0;
	assign jp1[8] = 1'b0;
	assign jp1[7:0] = 8'd0;
	assign jp2[17] = 1'b0;
	assign jp2[14] = 1'b0;
	assign jp2[12] = 1'b0;
	assign jp2[10] = 1'b0;
	assign jp2[8] = 1'b0;
	assign jp2[7:0] = 8'd0;

	main main_i (
		.sysclk(sysclk),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.line_in(line_in),
		.strobe(strobe),
		.smpclk(smpclk)
	);

endmodule

// File: tb_xc_firmware.sv
`timescale 1ns/1ps

module tb_xc_firmware;
	import xc_pkg::*;
	import xc_uart_pkg::*;

	localparam int idle_limit = 4000; // longest wait for a start bit, in clock cycles.
	localparam logic [19:0] jp1_used = 20'h8aa00; // pins 19, 15, 13, 11 and 9.
	localparam logic [19:0] jp2_used = 20'hdaa00; // pins 19, 18, 16, 15, 13, 11 and 9.

	logic sysclk;
	logic reset;
	logic rx_pin; // serial commands into the DUT.
	logic strobe_pin; // external sample strobe.
	logic [num_lines-1:0] lines; // levels driven onto the eight line pins.
	wire [19:0] jp1;
	wire [19:0] jp2;

	integer seed; // state of the random sequence.
	int error_count;
	int check_count;
	bit model_run; // modelled integration flag.
	logic [count_width-1:0] model_counts [num_counts]; // auto counts, then the cross pairs.
	logic [7:0] frame [frame_bytes]; // last frame taken from the tx pin.
	int strobes_given; // every strobe, running or not.
	int smpclk_changes; // level changes seen on the monitor pin.
	logic smpclk_last;

	assign jp1[15] = lines[0]; // lines 0 to 3 enter on the first header.
	assign jp1[13] = lines[1];
	assign jp1[11] = lines[2];
	assign jp1[9] = lines[3];
	assign jp2[15] = lines[4]; // lines 4 to 7 enter on the second header.
	assign jp2[13] = lines[5];
	assign jp2[11] = lines[6];
	assign jp2[9] = lines[7];
	assign jp2[16] = strobe_pin;
	assign jp2[19] = rx_pin;

	xc_firmware xc_firmware_i (
		.sysclk(sysclk),
		.reset(reset),
		.jp1(jp1),
		.jp2(jp2)
	);

	initial begin
		sysclk = 1'b0;
		forever #2 sysclk = ~sysclk; // 4 ns period.
	end

	// the monitor pin is watched on the falling edge, away from the DUT updates.
	always @(negedge sysclk) begin
		if (!reset && jp1[19] !== smpclk_last)
			smpclk_changes++;
		smpclk_last = jp1[19];
	end

	task automatic expect_true(input bit ok, input string msg);
		check_count++;
		assert (ok) else begin
			error_count++;
			$display("FAIL %0t: %s", $time, msg);
		end
	endtask

	// inputs always change 1 ns after a rising edge.
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
		#1;
	endtask

	// a header pin without a function is either driven low or left floating.
	function automatic bit spare_pins_quiet(input logic [19:0] pins, input logic [19:0] used);
		for (int i = 0; i < 20; i++) begin
			if (!used[i] && pins[i] !== 1'b0 && pins[i] !== 1'bz)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic void clear_model();
		for (int c = 0; c < num_counts; c++)
			model_counts[c] = '0;
	endfunction

	// cross counters follow the pair order (0,1), (0,2) ... (6,7).
	function automatic void count_sample(input logic [num_lines-1:0] word);
		int k;
		k = num_lines;
		for (int i = 0; i < num_lines; i++) begin
			if (word[i])
				model_counts[i] = model_counts[i] + 1'b1; // wraps at 16 bits like the DUT.
			for (int j = i + 1; j < num_lines; j++) begin
				if (word[i] && word[j])
					model_counts[k] = model_counts[k] + 1'b1;
				k++;
			end
		end
	endfunction

	task automatic give_strobes(input int n);
		logic [num_lines-1:0] word;
		for (int s = 0; s < n; s++) begin
			word = num_lines'($random(seed));
			lines = word; // lines stay put through the whole high phase.
			strobe_pin = 1'b1;
			if (model_run)
				count_sample(word);
			strobes_given++;
			wait_cycles(3 + {$random(seed)} % 6); // high for 3 to 8 cycles.
			strobe_pin = 1'b0;
			wait_cycles(3 + {$random(seed)} % 6);
		end
		expect_true(smpclk_changes == strobes_given,
			$sformatf("smpclk changed %0d times for %0d strobes", smpclk_changes, strobes_given));
	endtask

	task automatic send_byte(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0}; // stop bit, data lsb first, start bit.
		for (int b = 0; b < 10; b++) begin
			rx_pin = bits[b];
			wait_cycles(clks_per_bit);
		end
	endtask

	task automatic send_command(input logic [7:0] cmd);
		send_byte(cmd);
		wait_cycles(4); // the command has acted by now.
	endtask

	// every bit is sampled in its middle on a falling clock edge.
	task automatic receive_byte(output logic [7:0] data, output bit ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		data = '0;
		do begin
			@(negedge sysclk);
			waited++;
		end while (jp2[18] !== 1'b0 && waited < idle_limit);
		if (jp2[18] !== 1'b0) begin
			error_count++;
			$display("timeout: the DUT sent no start bit within %0d cycles", idle_limit);
			return;
		end
		repeat (clks_per_bit / 2) @(negedge sysclk);
		expect_true(jp2[18] === 1'b0, "start bit from the DUT is too short");
		for (int b = 0; b < 8; b++) begin
			repeat (clks_per_bit) @(negedge sysclk);
			data[b] = jp2[18];
		end
		repeat (clks_per_bit) @(negedge sysclk);
		expect_true(jp2[18] === 1'b1, "stop bit from the DUT is not high");
		ok = 1'b1;
	endtask

	task automatic receive_frame(output bit ok);
		logic [7:0] data;
		ok = 1'b1;
		for (int i = 0; i < frame_bytes && ok; i++) begin
			receive_byte(data, ok);
			frame[i] = data;
		end
	endtask

	// the answer can start before the stop bit of the command has ended.
	task automatic read_and_check(input string what);
		bit ok;
		fork
			send_byte(cmd_read);
			receive_frame(ok);
		join
		if (ok) begin
			expect_true(frame[0] === frame_header,
				$sformatf("%s: header is %02h", what, frame[0]));
			for (int c = 0; c < num_counts; c++) begin
				expect_true({frame[2*c+2], frame[2*c+1]} === model_counts[c],
					$sformatf("%s: count %0d is %04h, expected %04h", what, c,
					{frame[2*c+2], frame[2*c+1]}, model_counts[c]));
			end
		end
		wait_cycles(4);
	endtask

	initial begin
		seed = 32'h834f40c6;
		error_count = 0;
		check_count = 0;
		model_run = 1'b0;
		strobes_given = 0;
		smpclk_changes = 0;
		smpclk_last = 1'b0;
		reset = 1'b1;
		rx_pin = 1'b1; // the serial line idles high.
		strobe_pin = 1'b0;
		lines = '0;
		clear_model();
		repeat (2) @(posedge sysclk);
		#1;
		reset = 1'b0;

		// the link stays quiet after reset.
		for (int i = 0; i < 200; i++) begin
			@(negedge sysclk);
			expect_true(jp2[18] === 1'b1, "tx pin left its idle level after reset");
			expect_true(spare_pins_quiet(jp1, jp1_used) && spare_pins_quiet(jp2, jp2_used),
				"a header pin without a function is driven high or unknown");
		end
		wait_cycles(1);

		send_command(cmd_start);
		clear_model();
		model_run = 1'b1;
		give_strobes(60);
		read_and_check("after start");

		// strobes after a stop only move the monitor pin.
		send_command(cmd_stop);
		model_run = 1'b0;
		give_strobes(20);
		read_and_check("after stop");

		send_command(cmd_start);
		clear_model();
		model_run = 1'b1;
		read_and_check("after restart");
		give_strobes(25);
		read_and_check("strobes after restart");

		send_command(8'h78); // ascii x.
		read_and_check("after unknown byte");
		give_strobes(10);
		read_and_check("strobes after unknown byte");

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: flist.f
xc_pkg.sv
xc_uart_pkg.sv
xc_line_sampler.sv
xc_correlator.sv
xc_uart_rx.sv
xc_uart_tx.sv
xc_frame_sender.sv
main.sv
xc_firmware.sv
tb_xc_firmware.sv

// File: Bender.yml
package:
  name: xc_firmware

sources:
  - xc_pkg.sv
  - xc_uart_pkg.sv
  - xc_line_sampler.sv
  - xc_correlator.sv
  - xc_uart_rx.sv
  - xc_uart_tx.sv
  - xc_frame_sender.sv
  - main.sv
  - xc_firmware.sv
  - target: test
    files:
      - tb_xc_firmware.sv
